//--- logic/frontend_pkg.sv
// Front end widths, micro-op encoding, instruction word views and pipeline packet types
package frontend_pkg;

    localparam int XLEN           = 32;
    localparam int PC_BITS        = 32;
    localparam int REG_ADDR_BITS  = 5;
    localparam int QUEUE_DEPTH    = 4;
    localparam int QUEUE_PTR_BITS = 2;
    localparam int IMM12_BITS     = 12;

    // Major opcodes recognised by the decoder
    localparam logic [6:0] OPCODE_ALU_REG = 7'b0110011;
    localparam logic [6:0] OPCODE_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD    = 7'b0000011;

    //////////////////////////////
    // Decode rule
    //  rd, rs1 and funct3 always come from their fixed fields
    //  ALU_REG takes rs2 and funct7 from the R view, imm is zero
    //  ALU_IMM and LOAD sign-extend imm12, rs2 and funct7 are zero
    //  ILLEGAL zeroes rd, rs2, imm and funct7
    //  pc and taken_branch pass through unchanged
    //////////////////////////////
    typedef enum logic [1:0] {
        UOP_ALU_REG = 2'd0,
        UOP_ALU_IMM = 2'd1,
        UOP_LOAD    = 2'd2,
        UOP_ILLEGAL = 2'd3
    } uop_t;

    typedef struct packed {
        logic [6:0]               funct7;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } r_fields_t;

    typedef struct packed {
        logic [IMM12_BITS-1:0]    imm12;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [6:0]               opcode;
    } i_fields_t;

    // Same 32-bit word seen as R-type or I-type
    typedef union packed {
        r_fields_t r_view;
        i_fields_t i_view;
    } instr_word_t;

    typedef struct packed {
        logic [PC_BITS-1:0] pc;
        instr_word_t        data;
        logic               taken_branch;
    } fetched_packet_t;

    // Slot a is always valid inside a transferred pair
    typedef struct packed {
        fetched_packet_t slot_a;
        fetched_packet_t slot_b;
        logic            valid_b;
    } fetch_pair_t;

    typedef struct packed {
        logic [PC_BITS-1:0]       pc;
        uop_t                     microop;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic [XLEN-1:0]          imm;
        logic [2:0]               funct3;
        logic [6:0]               funct7;
        logic                     taken_branch;
    } decoded_instr_t;

    typedef struct packed {
        decoded_instr_t slot_a;
        decoded_instr_t slot_b;
        logic           valid_b;
    } decoded_pair_t;

endpackage

//--- logic/pipe_buffer.sv
// Two-entry elastic pipeline register with registered ready and flush
module pipe_buffer #(
    parameter int DATA_BITS = 32
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 flush_i,
    input  logic                 valid_i,
    input  logic [DATA_BITS-1:0] data_i,
    output logic                 ready_o,
    output logic                 valid_o,
    output logic [DATA_BITS-1:0] data_o,
    input  logic                 ready_i
);

    logic                 main_valid;
    logic [DATA_BITS-1:0] main_data;
    logic                 skid_valid;
    logic [DATA_BITS-1:0] skid_data;
    logic                 in_fire;
    logic                 out_fire;
    logic                 load_main;
    logic                 load_skid;

    // Ready only depends on the skid flop
    assign ready_o  = ~skid_valid;
    assign valid_o  = main_valid;
    assign data_o   = main_data;

    assign in_fire  = valid_i & ready_o;
    assign out_fire = main_valid & ready_i;

    // Main slot refills when empty or drained, skid catches a word while blocked
    assign load_main = ~main_valid | out_fire;
    assign load_skid = in_fire & main_valid & ~ready_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_main) begin
            main_valid <= skid_valid | in_fire;
            skid_valid <= 1'b0;
        end else if (load_skid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_main) begin
            main_data <= skid_valid ? skid_data : data_i;
        end
        if (load_skid) begin
            skid_data <= data_i;
        end
    end

endmodule

//--- logic/pair_decoder.sv
// Combinational decoder for both slots of a fetched instruction pair
module pair_decoder (
    input  frontend_pkg::fetch_pair_t   pair_i,
    output frontend_pkg::decoded_pair_t decoded_o
);

    //////////////////////////////
    // Single slot decode
    //////////////////////////////
    function automatic frontend_pkg::decoded_instr_t decode_slot(
        input frontend_pkg::fetched_packet_t slot
    );
        frontend_pkg::decoded_instr_t d;
        d.pc           = slot.pc;
        d.taken_branch = slot.taken_branch;
        // Fixed fields, same position in both views
        d.rd           = slot.data.r_view.rd;
        d.rs1          = slot.data.r_view.rs1;
        d.funct3       = slot.data.r_view.funct3;
        d.rs2          = '0;
        d.imm          = '0;
        d.funct7       = '0;
        case (slot.data.r_view.opcode)
            frontend_pkg::OPCODE_ALU_REG: begin
                d.microop = frontend_pkg::UOP_ALU_REG;
                d.rs2     = slot.data.r_view.rs2;
                d.funct7  = slot.data.r_view.funct7;
            end
            frontend_pkg::OPCODE_ALU_IMM,
            frontend_pkg::OPCODE_LOAD: begin
                if (slot.data.i_view.opcode == frontend_pkg::OPCODE_LOAD) begin
                    d.microop = frontend_pkg::UOP_LOAD;
                end else begin
                    d.microop = frontend_pkg::UOP_ALU_IMM;
                end
                // Sign extend the 12-bit immediate
                d.imm = {{(frontend_pkg::XLEN - frontend_pkg::IMM12_BITS)
                          {slot.data.i_view.imm12[frontend_pkg::IMM12_BITS-1]}},
                         slot.data.i_view.imm12};
            end
            default: begin
                d.microop = frontend_pkg::UOP_ILLEGAL;
                d.rd      = '0;
            end
        endcase
        return d;
    endfunction

    always_comb begin
        decoded_o.slot_a  = decode_slot(pair_i.slot_a);
        decoded_o.slot_b  = decode_slot(pair_i.slot_b);
        decoded_o.valid_b = pair_i.valid_b;
    end

endmodule

//--- logic/issue_queue.sv
// Dual-push dual-pop circular instruction queue with flush
module issue_queue (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         flush_i,
    input  logic                         push_valid_i,
    input  frontend_pkg::decoded_pair_t  push_pair_i,
    output logic                         push_ready_o,
    output logic                         head_valid_o,
    output frontend_pkg::decoded_instr_t head_o,
    output logic                         second_valid_o,
    output frontend_pkg::decoded_instr_t second_o,
    input  logic                         pop_head_i,
    input  logic                         pop_second_i
);

    frontend_pkg::decoded_instr_t mem [frontend_pkg::QUEUE_DEPTH];

    logic [frontend_pkg::QUEUE_PTR_BITS-1:0] wr_ptr;
    logic [frontend_pkg::QUEUE_PTR_BITS-1:0] wr_ptr_plus1;
    logic [frontend_pkg::QUEUE_PTR_BITS-1:0] rd_ptr;
    logic [frontend_pkg::QUEUE_PTR_BITS-1:0] rd_ptr_plus1;
    logic [frontend_pkg::QUEUE_PTR_BITS:0]   count;
    logic [frontend_pkg::QUEUE_PTR_BITS:0]   push_num;
    logic [frontend_pkg::QUEUE_PTR_BITS:0]   pop_num;
    logic                                    push_fire;
    logic                                    pop_head;
    logic                                    pop_second;

    // Depth is a power of two, so pointers wrap on their own
    assign wr_ptr_plus1 = wr_ptr + 1'b1;
    assign rd_ptr_plus1 = rd_ptr + 1'b1;

    //////////////////////////////
    // Status and pop side
    //////////////////////////////
    // Room for a full pair is required, whatever valid_b says
    assign push_ready_o   = (count <= (frontend_pkg::QUEUE_DEPTH - 2));
    assign head_valid_o   = (count != '0);
    assign second_valid_o = (count >= 2);
    assign head_o         = mem[rd_ptr];
    assign second_o       = mem[rd_ptr_plus1];

    assign push_fire  = push_valid_i & push_ready_o & ~flush_i;
    assign pop_head   = pop_head_i & head_valid_o & ~flush_i;
    assign pop_second = pop_head & pop_second_i & second_valid_o;

    always_comb begin
        push_num = '0;
        if (push_fire) begin
            push_num = push_pair_i.valid_b ? 2 : 1;
        end
        pop_num = '0;
        if (pop_second) begin
            pop_num = 2;
        end else if (pop_head) begin
            pop_num = 1;
        end
    end

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + push_num[frontend_pkg::QUEUE_PTR_BITS-1:0];
            rd_ptr <= rd_ptr + pop_num[frontend_pkg::QUEUE_PTR_BITS-1:0];
            count  <= count + push_num - pop_num;
        end
    end

    // Entry storage, slot a lands first
    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_pair_i.slot_a;
            if (push_pair_i.valid_b) begin
                mem[wr_ptr_plus1] <= push_pair_i.slot_b;
            end
        end
    end

endmodule

//--- logic/frontend_top.sv
// Front end top level with IF/ID buffer, pair decoder, ID/RR buffer and issue queue
module frontend_top (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         flush_i,
    input  logic                         fetch_valid_i,
    input  frontend_pkg::fetch_pair_t    fetch_pair_i,
    output logic                         fetch_ready_o,
    output logic                         head_valid_o,
    output frontend_pkg::decoded_instr_t head_o,
    output logic                         second_valid_o,
    output frontend_pkg::decoded_instr_t second_o,
    input  logic                         pop_head_i,
    input  logic                         pop_second_i
);

    //////////////////////////////
    // IF/ID pipeline register
    //////////////////////////////
    logic                        if_id_valid;
    logic                        id_rr_ready;
    frontend_pkg::fetch_pair_t   if_id_pair;

    pipe_buffer #(
        .DATA_BITS($bits(frontend_pkg::fetch_pair_t))
    ) if_id_buffer (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .valid_i (fetch_valid_i),
        .data_i  (fetch_pair_i),
        .ready_o (fetch_ready_o),
        .valid_o (if_id_valid),
        .data_o  (if_id_pair),
        .ready_i (id_rr_ready)
    );

    // Decode stage, no storage
    frontend_pkg::decoded_pair_t id_pair;

    pair_decoder pair_decoder (
        .pair_i    (if_id_pair),
        .decoded_o (id_pair)
    );

    //////////////////////////////
    // ID/RR pipeline register
    //////////////////////////////
    logic                        rr_valid;
    logic                        queue_ready;
    frontend_pkg::decoded_pair_t rr_pair;

    pipe_buffer #(
        .DATA_BITS($bits(frontend_pkg::decoded_pair_t))
    ) id_rr_buffer (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .valid_i (if_id_valid),
        .data_i  (id_pair),
        .ready_o (id_rr_ready),
        .valid_o (rr_valid),
        .data_o  (rr_pair),
        .ready_i (queue_ready)
    );

    issue_queue issue_queue (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .push_valid_i   (rr_valid),
        .push_pair_i    (rr_pair),
        .push_ready_o   (queue_ready),
        .head_valid_o   (head_valid_o),
        .head_o         (head_o),
        .second_valid_o (second_valid_o),
        .second_o       (second_o),
        .pop_head_i     (pop_head_i),
        .pop_second_i   (pop_second_i)
    );

endmodule

//--- verification/frontend_checker.sv
// Concurrent assertions on the front end top-level ports, bound into frontend_top
module frontend_checker (
    input logic clk,
    input logic reset_i,
    input logic pop_head_i,
    input logic pop_second_i,
    input logic head_valid_i,
    input logic second_valid_i
);

    // Read by the testbench
    int unsigned failures = 0;

    //////////////////////////////
    // Port rules
    //////////////////////////////
    idle_after_reset: assert property (
        @(posedge clk) reset_i |=> (!head_valid_i && !second_valid_i)
    ) else begin
        failures++;
        $error("Queue valid output high in the cycle after reset");
    end

    second_needs_head: assert property (
        @(posedge clk) disable iff (reset_i) second_valid_i |-> head_valid_i
    ) else begin
        failures++;
        $error("second_valid_o high while head_valid_o is low");
    end

    // Second slot only pops along with the head
    pop_second_with_head: assert property (
        @(posedge clk) disable iff (reset_i) pop_second_i |-> pop_head_i
    ) else begin
        failures++;
        $error("pop_second_i without pop_head_i");
    end

    pop_head_needs_valid: assert property (
        @(posedge clk) disable iff (reset_i) pop_head_i |-> head_valid_i
    ) else begin
        failures++;
        $error("pop_head_i while head_valid_o is low");
    end

    pop_second_needs_valid: assert property (
        @(posedge clk) disable iff (reset_i) pop_second_i |-> second_valid_i
    ) else begin
        failures++;
        $error("pop_second_i while second_valid_o is low");
    end

endmodule

bind frontend_top frontend_checker checker_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .pop_head_i     (pop_head_i),
    .pop_second_i   (pop_second_i),
    .head_valid_i   (head_valid_o),
    .second_valid_i (second_valid_o)
);

//--- verification/frontend_tb.sv
// Front end testbench with clock, reset, decode model, directed tests and compare tasks
module frontend_tb;

    localparam int WAIT_LIMIT = 200;

    logic                         clk;
    logic                         reset_i;
    logic                         flush_i;
    logic                         fetch_valid_i;
    frontend_pkg::fetch_pair_t    fetch_pair_i;
    logic                         fetch_ready_o;
    logic                         head_valid_o;
    frontend_pkg::decoded_instr_t head_o;
    logic                         second_valid_o;
    frontend_pkg::decoded_instr_t second_o;
    logic                         pop_head_i;
    logic                         pop_second_i;

    // Expected queue contents in transfer order, slot a first
    frontend_pkg::decoded_instr_t exp_q[$];
    logic [31:0]                  rng_state = 32'h8562_3df3;

    frontend_top uut (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_pair_i   (fetch_pair_i),
        .fetch_ready_o  (fetch_ready_o),
        .head_valid_o   (head_valid_o),
        .head_o         (head_o),
        .second_valid_o (second_valid_o),
        .second_o       (second_o),
        .pop_head_i     (pop_head_i),
        .pop_second_i   (pop_second_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        if (uut.checker_inst.failures != 0) begin
            report_failure("A bound checker assertion failed");
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_decoded(
        input string                        name,
        input frontend_pkg::decoded_instr_t got,
        input frontend_pkg::decoded_instr_t exp
    );
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    //////////////////////////////
    // Stimulus helpers and model
    //////////////////////////////
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic frontend_pkg::decoded_instr_t model_decode(
        input frontend_pkg::fetched_packet_t p
    );
        frontend_pkg::decoded_instr_t e;
        logic [31:0]                  w;
        w = p.data;
        e.pc = p.pc;
        e.taken_branch = p.taken_branch;
        e.rd = w[11:7];
        e.rs1 = w[19:15];
        e.funct3 = w[14:12];
        e.rs2 = '0;
        e.imm = '0;
        e.funct7 = '0;
        if (w[6:0] == 7'b0110011) begin
            e.microop = frontend_pkg::UOP_ALU_REG;
            e.rs2 = w[24:20];
            e.funct7 = w[31:25];
        end else if (w[6:0] == 7'b0010011 || w[6:0] == 7'b0000011) begin
            if (w[6:0] == 7'b0000011) begin
                e.microop = frontend_pkg::UOP_LOAD;
            end else begin
                e.microop = frontend_pkg::UOP_ALU_IMM;
            end
            e.imm = {{20{w[31]}}, w[31:20]};
        end else begin
            e.microop = frontend_pkg::UOP_ILLEGAL;
            e.rd = '0;
        end
        return e;
    endfunction

    function automatic frontend_pkg::fetched_packet_t make_packet(
        input logic [31:0] pc,
        input logic [31:0] word,
        input logic        taken
    );
        frontend_pkg::fetched_packet_t p;
        p.pc = pc;
        p.data = word;
        p.taken_branch = taken;
        return p;
    endfunction

    function automatic frontend_pkg::fetched_packet_t random_packet();
        logic [31:0] r;
        logic [31:0] sel;
        logic [6:0]  opcode;
        r = next_rand();
        sel = next_rand();
        case (sel[1:0])
            2'd0: opcode = 7'b0110011;
            2'd1: opcode = 7'b0010011;
            2'd2: opcode = 7'b0000011;
            default: opcode = sel[14:8];
        endcase
        return make_packet(next_rand() & 32'hffff_fffc, {r[31:7], opcode}, sel[2]);
    endfunction

    function automatic frontend_pkg::fetch_pair_t random_pair();
        frontend_pkg::fetch_pair_t pair;
        logic [31:0]               r;
        pair.slot_a = random_packet();
        pair.slot_b = random_packet();
        r = next_rand();
        pair.valid_b = r[3];
        return pair;
    endfunction

    // One clock cycle from 1 unit after an edge to 1 unit after the next
    task automatic run_cycle(
        input  logic                      offer,
        input  frontend_pkg::fetch_pair_t pair,
        input  int                        pop_want,
        output logic                      taken
    );
        logic ph;
        logic ps;
        fetch_valid_i = offer;
        fetch_pair_i = pair;
        if (head_valid_o) begin
            if (exp_q.size() < 1) report_failure("Queue shows a head entry that was never fetched");
            check_decoded("head_o", head_o, exp_q[0]);
        end
        if (second_valid_o) begin
            if (exp_q.size() < 2) report_failure("Queue shows a second entry that was never fetched");
            check_decoded("second_o", second_o, exp_q[1]);
        end
        ph = (pop_want >= 1) && head_valid_o;
        ps = (pop_want >= 2) && second_valid_o && ph;
        pop_head_i = ph;
        pop_second_i = ps;
        if (ph) void'(exp_q.pop_front());
        if (ps) void'(exp_q.pop_front());
        taken = offer && fetch_ready_o;
        if (taken) begin
            exp_q.push_back(model_decode(pair.slot_a));
            if (pair.valid_b) exp_q.push_back(model_decode(pair.slot_b));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_pair(input frontend_pkg::fetch_pair_t pair, input int pop_want);
        logic taken;
        int   n;
        taken = 1'b0;
        n = 0;
        while (!taken && n < WAIT_LIMIT) begin
            run_cycle(1'b1, pair, pop_want, taken);
            n++;
        end
        if (!taken) report_failure("fetch_ready_o stayed low and a pair was never accepted");
    endtask

    task automatic drain(input int pop_want);
        logic taken;
        int   n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            run_cycle(1'b0, '0, pop_want, taken);
            n++;
        end
        if (exp_q.size() != 0) report_failure("Expected entries never reached the queue head");
        // Pipeline is empty, nothing else may show up
        repeat (3) run_cycle(1'b0, '0, 0, taken);
        check_bit("head_valid_o", head_valid_o, 1'b0);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_single_slot();
        frontend_pkg::fetched_packet_t a;
        logic [11:0]                   imm;
        logic [31:0]                   r;
        for (int k = 0; k < 10; k++) begin
            imm = 12'(k * 409 - 1800);
            r = next_rand();
            a = make_packet(32'h1000 + 8 * k, {imm, r[19:15], r[14:12], r[11:7], 7'b0010011}, k[0]);
            // Slot b carries junk that must be ignored
            send_pair('{slot_a: a, slot_b: random_packet(), valid_b: 1'b0}, 1);
        end
        drain(1);
    endtask

    task automatic test_dual_slot();
        frontend_pkg::fetched_packet_t a;
        frontend_pkg::fetched_packet_t b;
        logic [31:0]                   r;
        for (int k = 0; k < 6; k++) begin
            r = next_rand();
            a = make_packet(32'h2000 + 8 * k,
                {k[0] ? 7'h20 : 7'h00, r[24:20], r[19:15], r[14:12], r[11:7], 7'b0110011}, 1'b0);
            b = make_packet(32'h2004 + 8 * k,
                {r[31:20], r[9:5], 3'b010, r[4:0], 7'b0000011}, k[1]);
            send_pair('{slot_a: a, slot_b: b, valid_b: 1'b1}, 2);
        end
        drain(2);
    endtask

    task automatic test_illegal();
        logic [6:0]                    opcodes [6];
        frontend_pkg::fetched_packet_t a;
        frontend_pkg::fetched_packet_t b;
        logic [31:0]                   r;
        opcodes = '{7'b1100011, 7'b0110111, 7'b1101111, 7'b1111111, 7'b0100011, 7'b0001111};
        for (int k = 0; k < 3; k++) begin
            r = next_rand();
            a = make_packet(32'h3000 + 8 * k, {r[31:7], opcodes[2 * k]}, 1'b1);
            b = make_packet(32'h3004 + 8 * k, {~r[31:7], opcodes[2 * k + 1]}, k[0]);
            send_pair('{slot_a: a, slot_b: b, valid_b: 1'b1}, 2);
        end
        drain(2);
    endtask

    task automatic test_back_pressure();
        frontend_pkg::fetch_pair_t pair;
        logic                      taken;
        int                        low_run;
        int                        n;
        low_run = 0;
        n = 0;
        pair = random_pair();
        while (low_run < 5 && n < WAIT_LIMIT) begin
            run_cycle(1'b1, pair, 0, taken);
            if (taken) begin
                low_run = 0;
                pair = random_pair();
            end else begin
                low_run++;
            end
            n++;
        end
        if (low_run < 5) report_failure("fetch_ready_o never stayed low with no pops");
        check_bit("fetch_ready_o", fetch_ready_o, 1'b0);
        // A queue with no room for a pair holds at least three entries
        check_bit("head_valid_o", head_valid_o, 1'b1);
        check_bit("second_valid_o", second_valid_o, 1'b1);
        drain(2);
    endtask

    task automatic test_flush();
        logic taken;
        for (int k = 0; k < 3; k++) begin
            send_pair(random_pair(), 0);
        end
        run_cycle(1'b0, '0, 0, taken);
        check_bit("head_valid_o", head_valid_o, 1'b1);
        flush_i = 1'b1;
        fetch_valid_i = 1'b0;
        pop_head_i = 1'b0;
        pop_second_i = 1'b0;
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        exp_q.delete();
        check_bit("head_valid_o", head_valid_o, 1'b0);
        check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
        for (int k = 0; k < 4; k++) begin
            send_pair(random_pair(), 2);
        end
        drain(2);
    endtask

    task automatic test_random_mix();
        frontend_pkg::fetch_pair_t pair;
        logic                      pending;
        logic                      taken;
        logic [31:0]               r;
        pending = 1'b0;
        pair = '0;
        for (int c = 0; c < 200; c++) begin
            r = next_rand();
            // Offered pair is held until accepted
            if (!pending) begin
                pending = (r[1:0] != 2'b00);
                pair = random_pair();
            end
            run_cycle(pending, pair, int'(r[5:4]) % 3, taken);
            if (taken) pending = 1'b0;
        end
        drain(2);
    endtask

    initial begin
        reset_i = 1'b1;
        flush_i = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pair_i = '0;
        pop_head_i = 1'b0;
        pop_second_i = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
        check_bit("head_valid_o", head_valid_o, 1'b0);
        check_bit("second_valid_o", second_valid_o, 1'b0);
        test_single_slot();
        test_dual_slot();
        test_illegal();
        test_back_pressure();
        test_flush();
        test_random_mix();
        if (exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_failure("Expected entries were left over at the end of the run");
        end
    end

endmodule

//--- build.f
logic/frontend_pkg.sv
logic/pipe_buffer.sv
logic/pair_decoder.sv
logic/issue_queue.sv
logic/frontend_top.sv
verification/frontend_checker.sv
verification/frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert --timing -Wno-fatal --top-module frontend_tb \
    -f build.f -Mdir "$BUILD_DIR" -o frontend_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"$BUILD_DIR/frontend_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F "*** TEST FAILED ***" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi
if ! grep -q -F "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
exit 0
